//--- cpuPkg.sv
/*
 * Shared types and constants for the single-cycle 16-bit core.
 * Every stage module pulls these in through a wildcard import.
 */
`default_nettype none

package cpuPkg;

   localparam int dataWidth    = 16;
   localparam int regAddrWidth = 3;

   // Primary opcode, instruction bits 15 to 11
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opJal   = 5'b00110,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opLbi   = 5'b11000,
      opAdd   = 5'b11100,
      opSub   = 5'b11101,
      opXor   = 5'b11110,
      opAndn  = 5'b11111
   } opcodeE;

   // ALU operations, first operand is always rs
   typedef enum logic [2:0] {
      aluAdd,
      aluSub,     // second minus first
      aluXor,
      aluAndn,    // first and not second
      aluPassB
   } aluOpE;

   typedef enum logic [1:0] {
      wbAlu,
      wbMem,
      wbLink
   } wbSelE;

   typedef struct packed {
      aluOpE  aluOp;
      logic   aluSrcImm;
      logic   memRead;
      logic   memWrite;
      logic   regWrite;
      wbSelE  wbSel;
      opcodeE branch;     // opNop when not a branch
      logic   jump;
      logic   halt;
   } ctrlT;

   // One committing instruction as seen from outside
   typedef struct packed {
      logic                    valid;
      logic [dataWidth-1:0]    pc;
      logic                    regWe;
      logic [regAddrWidth-1:0] regAddr;
      logic [dataWidth-1:0]    regData;
      logic                    memWe;
      logic [dataWidth-1:0]    memAddr;
      logic [dataWidth-1:0]    memData;
   } retireT;

endpackage

`default_nettype wire

//--- fetch.sv
/*
 * Fetch stage. Holds the program counter and the instruction memory.
 * The memory is loaded through the prog port while rst is high.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch import cpuPkg::*; #(
   parameter int imemDepth = 256
) (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         progWe,
   input  wire logic [$clog2(imemDepth)-1:0] progAddr,
   input  wire logic [dataWidth-1:0]         progData,
   input  wire logic [dataWidth-1:0]         newPc,
   input  wire logic                         stop,
   output logic      [dataWidth-1:0]         instr,
   output logic      [dataWidth-1:0]         pcCurrent,
   output logic      [dataWidth-1:0]         pcNext1
);

   logic [dataWidth-1:0] imem [imemDepth];
   logic                 halted;

   // Program load only while the core sits in reset
   always_ff @(posedge clk) begin
      if (rst && progWe) begin
         imem[progAddr] <= progData;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pcCurrent <= '0;
         halted    <= 1'b0;
      end else begin
         if (!stop && !halted) begin
            pcCurrent <= newPc;
         end
         if (stop) begin
            halted <= 1'b1;
         end
      end
   end

   assign instr   = imem[pcCurrent[$clog2(imemDepth)-1:0]];
   assign pcNext1 = pcCurrent + 1'b1;

endmodule

`default_nettype wire

//--- decode.sv
/*
 * Decode stage. Turns the opcode into control, reads the register file,
 * extends the immediate and flags undefined opcodes with a sticky err.
 */
`timescale 1ns/1ps
`default_nettype none

module decode import cpuPkg::*; (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic [dataWidth-1:0]    instr,
   input  wire logic [dataWidth-1:0]    wbData,
   output ctrlT                         ctrl,
   output logic      [dataWidth-1:0]    rsData,
   output logic      [dataWidth-1:0]    rtData,
   output logic      [dataWidth-1:0]    imm,
   output logic      [regAddrWidth-1:0] wbAddr,
   output logic                         err
);

   logic [dataWidth-1:0]    regs [2**regAddrWidth];
   logic [regAddrWidth-1:0] rs;
   logic [regAddrWidth-1:0] rt;
   logic [regAddrWidth-1:0] rd;
   opcodeE                  opcode;
   logic                    illegal;

   assign opcode = opcodeE'(instr[15:11]);
   assign rs     = instr[10:8];
   assign rt     = instr[7:5];
   assign rd     = instr[4:2];

   always_comb begin
      ctrl        = '0;
      ctrl.aluOp  = aluAdd;
      ctrl.wbSel  = wbAlu;
      ctrl.branch = opNop;
      illegal     = 1'b0;
      wbAddr      = rt;
      // I-type imm5 unless overridden below
      imm = {{(dataWidth-5){instr[4]}}, instr[4:0]};
      case (opcode)
         opHalt: ctrl.halt = 1'b1;
         opNop:  ;
         opAddi, opSubi, opXori, opAndni: begin
            ctrl.aluOp     = (opcode == opAddi) ? aluAdd :
                             (opcode == opSubi) ? aluSub :
                             (opcode == opXori) ? aluXor : aluAndn;
            ctrl.aluSrcImm = 1'b1;
            ctrl.regWrite  = 1'b1;
         end
         opSt: begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.memWrite  = 1'b1;
         end
         opLd: begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.memRead   = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.wbSel     = wbMem;
         end
         opLbi: begin
            ctrl.aluOp     = aluPassB;
            ctrl.aluSrcImm = 1'b1;
            ctrl.regWrite  = 1'b1;
            wbAddr         = rs;
            imm            = {{(dataWidth-8){instr[7]}}, instr[7:0]};
         end
         opAdd, opSub, opXor, opAndn: begin
            ctrl.aluOp    = (opcode == opAdd) ? aluAdd :
                            (opcode == opSub) ? aluSub :
                            (opcode == opXor) ? aluXor : aluAndn;
            ctrl.regWrite = 1'b1;
            wbAddr        = rd;
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            ctrl.branch = opcode;
            imm         = {{(dataWidth-8){instr[7]}}, instr[7:0]};
         end
         opJ, opJal: begin
            ctrl.jump = 1'b1;
            imm       = {{(dataWidth-11){instr[10]}}, instr[10:0]};
            if (opcode == opJal) begin
               ctrl.regWrite = 1'b1;
               ctrl.wbSel    = wbLink;
               wbAddr        = 3'd7;
            end
         end
         default: begin
            illegal   = 1'b1;
            ctrl.halt = 1'b1;
         end
      endcase
   end

   assign rsData = regs[rs];
   assign rtData = regs[rt];

   always_ff @(posedge clk) begin
      if (rst) begin
         regs <= '{default: '0};
      end else if (ctrl.regWrite && !err) begin
         regs[wbAddr] <= wbData;
      end
   end

   // Sticky until the next reset
   always_ff @(posedge clk) begin
      if (rst) begin
         err <= 1'b0;
      end else if (illegal) begin
         err <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- execute.sv
/*
 * Execute stage. Purely combinational ALU plus the branch-condition
 * test of rs against zero.
 */
`timescale 1ns/1ps
`default_nettype none

module execute import cpuPkg::*; (
   input  ctrlT                      ctrl,
   input  wire logic [dataWidth-1:0] rsData,
   input  wire logic [dataWidth-1:0] rtData,
   input  wire logic [dataWidth-1:0] imm,
   output logic      [dataWidth-1:0] aluRes,
   output logic                      branchTaken
);

   logic [dataWidth-1:0] opB;
   logic                 rsZero;
   logic                 rsNeg;

   assign opB = ctrl.aluSrcImm ? imm : rtData;

   always_comb begin
      case (ctrl.aluOp)
         aluAdd:   aluRes = rsData + opB;
         aluSub:   aluRes = opB - rsData;
         aluXor:   aluRes = rsData ^ opB;
         aluAndn:  aluRes = rsData & ~opB;
         aluPassB: aluRes = opB;
         default:  aluRes = '0;
      endcase
   end

   assign rsZero = (rsData == '0);
   assign rsNeg  = rsData[dataWidth-1];

   // Branch kind travels as its opcode
   always_comb begin
      case (ctrl.branch)
         opBeqz:  branchTaken = rsZero;
         opBnez:  branchTaken = !rsZero;
         opBltz:  branchTaken = rsNeg;
         opBgez:  branchTaken = !rsNeg;
         default: branchTaken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- memWriteback.sv
/*
 * Memory and write-back. Holds the data memory, picks the next PC
 * and the value written back to the register file.
 */
`timescale 1ns/1ps
`default_nettype none

module memWriteback import cpuPkg::*; #(
   parameter int dmemDepth = 256
) (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  ctrlT                      ctrl,
   input  wire logic [dataWidth-1:0] aluRes,
   input  wire logic [dataWidth-1:0] rtData,
   input  wire logic [dataWidth-1:0] imm,
   input  wire logic [dataWidth-1:0] pcNext1,
   input  wire logic                 branchTaken,
   input  wire logic                 stall,
   output logic      [dataWidth-1:0] newPc,
   output logic      [dataWidth-1:0] wbData,
   output logic      [dataWidth-1:0] memReadData
);

   logic [dataWidth-1:0] dmem [dmemDepth];
   logic [dataWidth-1:0] target;
   logic                 memWe;

   // Stores never land while held in reset or after an error
   assign memWe = ctrl.memWrite && !stall && !rst;

   always_ff @(posedge clk) begin
      if (memWe) begin
         dmem[aluRes[$clog2(dmemDepth)-1:0]] <= rtData;
      end
   end

   assign memReadData = dmem[aluRes[$clog2(dmemDepth)-1:0]];

   // Branches and jumps are both relative to PC+1
   assign target = pcNext1 + imm;
   assign newPc  = ctrl.halt                    ? pcNext1 - 1'b1 :
                   (branchTaken || ctrl.jump)   ? target : pcNext1;

   always_comb begin
      case (ctrl.wbSel)
         wbMem:   wbData = memReadData;
         wbLink:  wbData = pcNext1;
         default: wbData = aluRes;
      endcase
   end

endmodule

`default_nettype wire

//--- proc.sv
/*
 * Top level of the single-cycle core. Wires the stages together and
 * reports each committing instruction on the retire port.
 */
`timescale 1ns/1ps
`default_nettype none

module proc import cpuPkg::*; #(
   parameter int imemDepth = 256,
   parameter int dmemDepth = 256
) (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         progWe,
   input  wire logic [$clog2(imemDepth)-1:0] progAddr,
   input  wire logic [dataWidth-1:0]         progData,
   output logic                              err,
   output retireT                            retire
);

   ctrlT                    ctrl;
   logic [dataWidth-1:0]    instr, pcCurrent, pcNext1, newPc;
   logic [dataWidth-1:0]    rsData, rtData, imm, aluRes, wbData, memReadData;
   logic [regAddrWidth-1:0] wbAddr;
   logic                    branchTaken;

   fetch #(.imemDepth(imemDepth)) fetch_i (
      .clk, .rst, .progWe, .progAddr, .progData, .newPc,
      .stop(ctrl.halt), .instr, .pcCurrent, .pcNext1
   );

   decode decode_i (
      .clk, .rst, .instr, .wbData, .ctrl, .rsData, .rtData, .imm, .wbAddr, .err
   );

   execute execute_i (
      .ctrl, .rsData, .rtData, .imm, .aluRes, .branchTaken
   );

   memWriteback #(.dmemDepth(dmemDepth)) memWriteback_i (
      .clk, .rst, .ctrl, .aluRes, .rtData, .imm, .pcNext1, .branchTaken,
      .stall(err), .newPc, .wbData, .memReadData
   );

   // Describes what commits on the coming edge
   always_comb begin
      retire.valid   = !rst && !ctrl.halt && !err;
      retire.pc      = pcCurrent;
      retire.regWe   = retire.valid && ctrl.regWrite;
      retire.regAddr = wbAddr;
      retire.regData = wbData;
      retire.memWe   = retire.valid && ctrl.memWrite;
      retire.memAddr = aluRes;
      // Store data on stores, the loaded word otherwise
      retire.memData = ctrl.memWrite ? rtData : memReadData;
   end

endmodule

`default_nettype wire

//--- procChecker.sv
/*
 * Testbench checker. Keeps an instruction-set model of the core, copies the
 * program from the load port, steps once per retired instruction and
 * compares the retire port and err against the model.
 */
`timescale 1ns/1ps
`default_nettype none

module procChecker import cpuPkg::*; (
   input wire logic                 clk,
   input wire logic                 rst,
   input wire logic                 progWe,
   input wire logic [7:0]           progAddr,
   input wire logic [dataWidth-1:0] progData,
   input wire logic                 err,
   input wire retireT               retire
);

   logic [15:0] progMem [256];
   logic [15:0] regs [8];
   logic [15:0] dmem [256];
   logic [15:0] modelPc;
   logic        modelErr;
   string       testName = "none";
   int          errorCount = 0;
   int          retireCount = 0;
   int          testErrors = 0;
   int          testRetires = 0;

   task automatic compare(input string field, input logic [15:0] expected,
                          input logic [15:0] actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s pc=0x%04h %s: expected 0x%04h actual 0x%04h",
                  testName, modelPc, field, expected, actual);
         errorCount++;
         testErrors++;
      end
   endtask

   task automatic beginTest(input string name);
      testName    = name;
      testErrors  = 0;
      testRetires = 0;
   endtask

   task automatic endTest();
      $display("test %s done: %0d retires, %0d errors", testName, testRetires, testErrors);
   endtask

   task automatic expectRetires(input int count);
      compare("retire count", count, testRetires);
   endtask

   task automatic resetModel();
      int r;
      modelPc  = '0;
      modelErr = 1'b0;
      for (r = 0; r < 8; r++) begin
         regs[r] = '0;
      end
   endtask

   // Model of one cycle against what the core commits on the next edge
   task automatic checkCycle();
      logic [15:0] w, a, b, imm5, imm8, imm11, nextPc, wData, mAddr;
      logic [2:0]  wAddr;
      logic        legal, wEn, mEn, expValid;
      opcodeE      op;
      w      = progMem[modelPc[7:0]];
      op     = opcodeE'(w[15:11]);
      a      = regs[w[10:8]];
      b      = regs[w[7:5]];
      imm5   = {{11{w[4]}}, w[4:0]};
      imm8   = {{8{w[7]}}, w[7:0]};
      imm11  = {{5{w[10]}}, w[10:0]};
      nextPc = modelPc + 16'd1;
      mAddr  = a + imm5;
      wAddr  = w[7:5];
      wData  = '0;
      legal  = 1'b1;
      mEn    = (op == opSt);
      wEn    = op inside {opAddi, opSubi, opXori, opAndni, opLd, opLbi,
                          opAdd, opSub, opXor, opAndn, opJal};
      case (op)
         opHalt, opNop, opSt: ;
         opAddi:  wData = a + imm5;
         opSubi:  wData = imm5 - a;
         opXori:  wData = a ^ imm5;
         opAndni: wData = a & ~imm5;
         opLd:    wData = dmem[mAddr[7:0]];
         opLbi: begin
            wAddr = w[10:8];
            wData = imm8;
         end
         opAdd:   wData = a + b;
         opSub:   wData = b - a;
         opXor:   wData = a ^ b;
         opAndn:  wData = a & ~b;
         opBeqz:  nextPc = (a == '0) ? nextPc + imm8 : nextPc;
         opBnez:  nextPc = (a != '0) ? nextPc + imm8 : nextPc;
         opBltz:  nextPc = a[15] ? nextPc + imm8 : nextPc;
         opBgez:  nextPc = !a[15] ? nextPc + imm8 : nextPc;
         opJ:     nextPc = nextPc + imm11;
         opJal: begin
            wAddr  = 3'd7;
            wData  = nextPc;
            nextPc = nextPc + imm11;
         end
         default: legal = 1'b0;
      endcase
      // R-type writes rd
      if (op inside {opAdd, opSub, opXor, opAndn}) begin
         wAddr = w[4:2];
      end
      expValid = legal && (op != opHalt) && !modelErr;
      compare("valid", expValid, retire.valid);
      compare("err", modelErr, err);
      if (!legal) begin
         modelErr = 1'b1;
      end
      if (expValid && retire.valid === 1'b1) begin
         compare("pc", modelPc, retire.pc);
         compare("regWe", wEn, retire.regWe);
         if (wEn) begin
            compare("regAddr", wAddr, retire.regAddr);
            compare("regData", wData, retire.regData);
            regs[wAddr] = wData;
         end
         compare("memWe", mEn, retire.memWe);
         if (mEn) begin
            compare("memAddr", mAddr, retire.memAddr);
            compare("memData", b, retire.memData);
            dmem[mAddr[7:0]] = b;
         end
         // Loads report the address and the word read
         if (op == opLd) begin
            compare("memAddr", mAddr, retire.memAddr);
            compare("memData", wData, retire.memData);
         end
         modelPc = nextPc;
         retireCount++;
         testRetires++;
      end
   endtask

   // Sampling mid-cycle where everything has settled
   always @(negedge clk) begin
      if (rst) begin
         if (progWe) begin
            progMem[progAddr] = progData;
         end
         resetModel();
      end else begin
         checkCycle();
      end
   end

endmodule

`default_nettype wire

//--- procTb.sv
/*
 * Top-level testbench for the single-cycle core. Loads a random program,
 * runs it to its halt, then loads a short program with an undefined opcode.
 * procChecker does all comparing; this module drives and sequences.
 */
`timescale 1ns/1ps
`default_nettype none

module procTb import cpuPkg::*; ();

   localparam int clkPeriod  = 20;
   localparam int progLen    = 120;
   localparam int errLen     = 6;
   localparam int errPos     = 3;
   localparam int holdCycles = 10;
   // Run time plus 20 spare cycles per program plus loading and hold time
   localparam int budgetCycles = (progLen + 20) + (errLen + 20)
                               + (progLen + errLen + 10) + 2 * holdCycles;

   logic        clk = 1'b0;
   logic        rst;
   logic        progWe;
   logic [7:0]  progAddr;
   logic [15:0] progData;
   logic        err;
   retireT      retire;
   logic [15:0] prog [progLen];
   integer      seed = 5872;
   opcodeE      bodyOps [18] = '{opNop, opAddi, opSubi, opXori, opAndni, opSt, opLd,
                                 opLbi, opAdd, opSub, opXor, opAndn, opBeqz, opBnez,
                                 opBltz, opBgez, opJ, opJal};

   proc #(.imemDepth(256), .dmemDepth(256)) dut_i (
      .clk, .rst, .progWe, .progAddr, .progData, .err, .retire
   );

   procChecker checkInst (
      .clk, .rst, .progWe, .progAddr, .progData, .err, .retire
   );

   always #(clkPeriod / 2) clk = ~clk;

   // Body never writes r6 so it stays the data pointer
   task automatic makeInstr(input int pc, output logic [15:0] w);
      logic [31:0] rnd;
      opcodeE      op;
      logic [2:0]  srcA, srcB, dst, memOff;
      int          off;
      op     = bodyOps[{$random(seed)} % 18];
      rnd    = $random(seed);
      srcA   = rnd[2:0];
      srcB   = rnd[5:3];
      dst    = rnd[8:6] % 6;
      memOff = rnd[24:22];
      // Forward only and never past the final halt
      off = rnd[27:25];
      if (off > progLen - 2 - pc) begin
         off = progLen - 2 - pc;
      end
      case (op)
         opAddi, opSubi, opXori, opAndni: w = {op, srcA, dst, rnd[13:9]};
         opSt:  w = {op, 3'd6, srcB, 2'b00, memOff};
         opLd:  w = {op, 3'd6, dst, 2'b00, memOff};
         opLbi: w = {op, dst, rnd[21:14]};
         opAdd, opSub, opXor, opAndn: w = {op, srcA, srcB, dst, 2'b00};
         opBeqz, opBnez, opBltz, opBgez: w = {op, srcA, 8'(off)};
         opJ, opJal: w = {op, 11'(off)};
         default: w = {opNop, 11'h000};
      endcase
   endtask

   task automatic buildRandomProgram();
      int i;
      prog[0] = {opLbi, 3'd6, 8'h20};
      for (i = 1; i < 6; i++) begin
         prog[i] = {opLbi, 3'(i), 8'($random(seed))};
      end
      // Fill all eight data words so every later ld hits a stored value
      for (i = 0; i < 8; i++) begin
         prog[6 + i] = {opSt, 3'd6, 3'(i % 6), 2'b00, 3'(i)};
      end
      for (i = 14; i < progLen - 1; i++) begin
         makeInstr(i, prog[i]);
      end
      prog[progLen - 1] = {opHalt, 11'h000};
   endtask

   task automatic buildErrorProgram();
      prog[0] = {opLbi, 3'd1, 8'd5};
      prog[1] = {opAddi, 3'd1, 3'd2, 5'd3};
      prog[2] = {opAdd, 3'd1, 3'd2, 3'd3, 2'b00};
      // No opcode is assigned to 00010
      prog[errPos] = {5'b00010, 11'h000};
      prog[4] = {opAddi, 3'd3, 3'd4, 5'd1};
      prog[5] = {opHalt, 11'h000};
   endtask

   task automatic loadProgram(input int len);
      int i;
      @(posedge clk);
      rst <= 1'b1;
      for (i = 0; i < len; i++) begin
         @(posedge clk);
         progWe   <= 1'b1;
         progAddr <= 8'(i);
         progData <= prog[i];
      end
      @(posedge clk);
      progWe <= 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
   endtask

   initial begin
      #(budgetCycles * clkPeriod);
      $display("Timeout: the core never halted within %0d cycles", budgetCycles);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      rst      = 1'b1;
      progWe   = 1'b0;
      progAddr = '0;
      progData = '0;
      buildRandomProgram();
      checkInst.beginTest("randomProgram");
      loadProgram(progLen);
      @(negedge clk);
      while (retire.valid !== 1'b0) @(negedge clk);
      // Let the checker finish the current cycle first
      @(posedge clk);
      checkInst.endTest();
      checkInst.beginTest("haltHold");
      repeat (holdCycles) @(negedge clk);
      @(posedge clk);
      checkInst.endTest();
      buildErrorProgram();
      checkInst.beginTest("illegalOpcode");
      loadProgram(errLen);
      while (err !== 1'b1) @(negedge clk);
      repeat (holdCycles) @(negedge clk);
      @(posedge clk);
      checkInst.expectRetires(errPos);
      checkInst.endTest();
      $display("tests 3, retires checked %0d, errors %0d",
               checkInst.retireCount, checkInst.errorCount);
      if (checkInst.errorCount == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
cpuPkg.sv
fetch.sv
decode.sv
execute.sv
memWriteback.sv
proc.sv
procChecker.sv
procTb.sv

//--- Bender.yml
package:
  name: proc

sources:
  - cpuPkg.sv
  - fetch.sv
  - decode.sv
  - execute.sv
  - memWriteback.sv
  - proc.sv
  - target: test
    files:
      - procChecker.sv
      - procTb.sv
